// ==== Bender.yml ====
package:
  name: thor_decode

sources:
  - files:
      - thor_isa_pkg.sv
      - thor_decode_pkg.sv
      - thor_reg_spec.sv
      - thor_const_gen.sv
      - thor_ctrl_class.sv
      - thor_decode_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_thor_decode.sv

// ==== project.f ====
+incdir+.
thor_isa_pkg.sv
thor_decode_pkg.sv
thor_reg_spec.sv
thor_const_gen.sv
thor_ctrl_class.sv
thor_decode_unit.sv
tb_thor_decode.sv

// ==== tb_thor_decode_vectors.svh ====
// Directed decode vectors, included into the body of the decode unit testbench
// Columns: insn, prefix, prefix_valid, ra, rb, rc, rt, rfwr, ld, ldz, st, memsz, jmp, jxx,
// then imm and jmptgt as 64-bit values whose sign is copied into the upper record bits
localparam int NUM_VEC = 13;

vec_t vec_table [NUM_VEC];

task automatic fill_vector_table;
	// Register operate and immediate padding
	vec_table[0] = '{{19'h0, 5'd3, 5'd2, 5'd1, 5'd4, 1'b0, R2}, 48'h0, 1'b0,
		5'd1, 5'd2, 5'd3, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'h0, 64'h620};
	vec_table[1] = '{{16'h0, 13'h1FFC, 5'd2, 5'd3, 1'b0, ADDI}, 48'h0, 1'b0,
		5'd2, 5'd28, 5'd31, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'hFFFF_FFFF_FFFF_FFFC, 64'h1FFC0};
	vec_table[2] = '{{16'h0, 13'h00F0, 5'd4, 5'd5, 1'b0, ANDI}, 48'h0, 1'b0,
		5'd4, 5'd16, 5'd7, 5'd5, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'hFFFF_FFFF_FFFF_E0F0, 64'hF02};
	vec_table[3] = '{{16'h0, 13'h1ABC, 5'd6, 5'd7, 1'b0, ORI}, 48'h0, 1'b0,
		5'd6, 5'd28, 5'd21, 5'd7, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'h1ABC, 64'h1ABC2};
	// EXI8 and EXI24 above the low 24 bits, then a prefix that is not valid
	vec_table[4] = '{{16'h0, 13'h0123, 5'd1, 5'd2, 1'b0, ADDI}, {32'h0, 7'h7F, 1'b0, EXI8}, 1'b1,
		5'd1, 5'd3, 5'd9, 5'd2, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'hFFFF_FFFF_FE00_0123, 64'h1230};
	vec_table[5] = '{{16'h0, 13'h0123, 5'd1, 5'd2, 1'b0, ADDI},
		{16'h0, 23'h40_0001, 1'b0, EXI24}, 1'b1,
		5'd1, 5'd3, 5'd9, 5'd2, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'hFFFF_8000_0200_0123, 64'h1230};
	vec_table[6] = '{{16'h0, 13'h0123, 5'd1, 5'd2, 1'b0, ADDI}, {32'h0, 7'h7F, 1'b0, EXI8}, 1'b0,
		5'd1, 5'd3, 5'd9, 5'd2, 1'b1, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'h123, 64'h1230};
	// Loads and stores
	vec_table[7] = '{{16'h0, 13'h1FF8, 5'd3, 5'd10, 1'b0, LDBU}, 48'h0, 1'b0,
		5'd3, 5'd24, 5'd31, 5'd10, 1'b1, 1'b1, 1'b1, 1'b0, byt, 1'b0, 1'b0,
		64'hFFFF_FFFF_FFFF_FFF8, 64'h1FF80};
	vec_table[8] = '{{16'h0, 13'h0010, 5'd4, 5'd11, 1'b0, LDW}, 48'h0, 1'b0,
		5'd4, 5'd16, 5'd0, 5'd11, 1'b1, 1'b1, 1'b0, 1'b0, wyde, 1'b0, 1'b0,
		64'h10, 64'h102};
	vec_table[9] = '{{16'h0, 13'h0000, 5'd5, 5'd12, 1'b0, LDO}, 48'h0, 1'b0,
		5'd5, 5'd0, 5'd0, 5'd12, 1'b1, 1'b1, 1'b0, 1'b0, octa, 1'b0, 1'b0,
		64'h0, 64'h2};
	vec_table[10] = '{{16'h0, 13'h0004, 5'd6, 5'd13, 1'b0, STB}, 48'h0, 1'b0,
		5'd6, 5'd4, 5'd13, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, byt, 1'b0, 1'b0,
		64'h4, 64'h42};
	// Branch targets
	vec_table[11] = '{{20'hFFFF0, 4'h0, 5'd9, 5'd8, 6'h0, JEQ}, 48'h0, 1'b0,
		5'd8, 5'd9, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, octa, 1'b0, 1'b1,
		64'h0, 64'hFFFF_FFFF_FFFF_FFE0};
	vec_table[12] = '{{32'h8000_0010, 8'h00, JMP}, 48'h0, 1'b0,
		5'd26, 5'd2, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, octa, 1'b1, 1'b0,
		64'h0, 64'hFFFF_FFFF_0000_0020};
endtask

// ==== tb_thor_decode.sv ====
// Testbench for the decode unit; runs the vector table and random ORI cases through the handshake
`timescale 1ns/1ps
`default_nettype none

module tb_thor_decode;

	import thor_isa_pkg::*;
	import thor_decode_pkg::*;

	localparam int VALUE_W  = 64;
	localparam int NUM_RAND = 16;

	// One table entry: stimulus and the expected decode record
	typedef struct packed {
		insn_t                 insn;
		logic [PREFIX_W-1:0]   prefix;
		logic                  pv;
		logic [REG_W-1:0]      ra;
		logic [REG_W-1:0]      rb;
		logic [REG_W-1:0]      rc;
		logic [REG_W-1:0]      rt;
		logic                  rfwr;
		logic                  ld;
		logic                  ldz;
		logic                  st;
		mem_size_e             memsz;
		logic                  jmp;
		logic                  jxx;
		logic [63:0]           imm;
		logic [63:0]           tgt;
	} vec_t;

	logic          clk;
	logic          reset;
	logic          req;
	logic          ack;
	decode_req_t   request;
	decode_out_t   decode;
	int            cycle_count;

	`include "tb_thor_decode_vectors.svh"

	// Each handshake needs about 6 cycles, plus reset
	localparam int TIMEOUT_CYCLES = 8 * (NUM_VEC + NUM_RAND) + 50;

	thor_decode_unit #(
		.VALUE_W (VALUE_W)
	) dut0 (
		.clk     (clk),
		.reset   (reset),
		.req     (req),
		.ack     (ack),
		.request (request),
		.decode  (decode)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout waiting for handshake after %0d cycles", cycle_count);
			$display("Test failed");
			$fatal(1, "simulation timeout");
		end
	end

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0d ns: %s: got %0h, expected %0h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Full four-phase exchange, returns the record seen while ack is high
	task automatic run_handshake(input decode_req_t r, output decode_out_t got);
		int waited;
		request = r;
		req = 1'b1;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!ack);
		// Capture edge plus two cycles
		check_value(waited, 3, "cycles from req to ack");
		got = decode;
		repeat (2)
		begin
			@(negedge clk);
			check_value(ack, 1'b1, "ack held while req high");
			check_value(decode === got, 1'b1, "decode held while req high");
		end
		req = 1'b0;
		@(negedge clk);
		check_value(ack, 1'b0, "ack low one cycle after req low");
	endtask

	task automatic check_record(input decode_out_t got, input vec_t v, input int idx);
		string tag;
		tag = $sformatf("vector %0d", idx);
		check_value(got.ra, v.ra, {tag, " ra"});
		check_value(got.rb, v.rb, {tag, " rb"});
		check_value(got.rc, v.rc, {tag, " rc"});
		check_value(got.rt, v.rt, {tag, " rt"});
		check_value(got.rfwr, v.rfwr, {tag, " rfwr"});
		check_value(got.ld, v.ld, {tag, " ld"});
		check_value(got.ldz, v.ldz, {tag, " ldz"});
		check_value(got.st, v.st, {tag, " st"});
		check_value(got.memsz, v.memsz, {tag, " memsz"});
		check_value(got.jmp, v.jmp, {tag, " jmp"});
		check_value(got.jxx, v.jxx, {tag, " jxx"});
		// Upper record bits are a sign copy of the 64-bit value
		check_value(got.imm, {{(VALUE_MAX-64){v.imm[63]}}, v.imm}, {tag, " imm"});
		check_value(got.jmptgt, {{(VALUE_MAX-64){v.tgt[63]}}, v.tgt}, {tag, " jmptgt"});
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin : main
		decode_out_t        got;
		decode_req_t        r;
		logic [31:0]        seed;
		logic [IMM_W-1:0]   field;
		logic [REG_W-1:0]   ra_sel;
		logic [REG_W-1:0]   rt_sel;

		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		request = '0;
		cycle_count = 0;
		fill_vector_table();

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value(ack, 1'b0, "ack after reset");

		for (int i = 0; i < NUM_VEC; i++)
		begin
			r.insn = vec_table[i].insn;
			r.prefix = vec_table[i].prefix;
			r.prefix_valid = vec_table[i].pv;
			run_handshake(r, got);
			check_record(got, vec_table[i], i);
		end

		// Random ORI immediates, expected by zero padding
		seed = 32'hb003ce5a;
		for (int n = 0; n < NUM_RAND; n++)
		begin
			seed = xorshift32(seed);
			field = seed[12:0];
			ra_sel = seed[17:13];
			rt_sel = seed[22:18];
			r.insn = {16'h0, field, ra_sel, rt_sel, 1'b0, ORI};
			r.prefix = '0;
			r.prefix_valid = 1'b0;
			run_handshake(r, got);
			check_value(got.imm, {{(VALUE_MAX-IMM_W){1'b0}}, field},
				$sformatf("random %0d imm", n));
			check_value(got.ra, ra_sel, $sformatf("random %0d ra", n));
			check_value(got.rt, rt_sel, $sformatf("random %0d rt", n));
			check_value(got.rfwr, 1'b1, $sformatf("random %0d rfwr", n));
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== thor_const_gen.sv ====
// Immediate and branch target formation with EXI prefix extension; combinational
`timescale 1ns/1ps
`default_nettype none

module thor_const_gen #(
	parameter int VALUE_W = 64
) (
	input  wire  thor_isa_pkg::insn_t                  insn,
	input  wire  thor_isa_pkg::insn_t                  prefix,
	input  wire                                        prefix_valid,
	output logic [thor_decode_pkg::VALUE_MAX-1:0]      imm,
	output logic [thor_decode_pkg::VALUE_MAX-1:0]      jmptgt
);

	import thor_isa_pkg::*;
	import thor_decode_pkg::*;

	opcode_e              opc;
	logic [IMM_W-1:0]     imm_field;
	logic [VALUE_W-1:0]   imm_base;
	logic [VALUE_W-1:0]   imm_ext;
	logic [VALUE_W-1:0]   tgt;

	assign opc       = opcode_of(insn);
	assign imm_field = insn[IMM_LSB +: IMM_W];

	// ============================================================
	// Base immediate
	// ============================================================
	always_comb
	begin
		case (opc)
		ADDI, LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO:
			imm_base = VALUE_W'($signed(imm_field));
		ANDI:
			// Ones to the left so the mask leaves upper bits alone
			imm_base = {{(VALUE_W-IMM_W){1'b1}}, imm_field};
		ORI, XORI:
			imm_base = VALUE_W'(imm_field);
		default:
			imm_base = '0;
		endcase
	end

	// Prefix supplies the bits above the low 24
	always_comb
	begin
		imm_ext = imm_base;
		if (prefix_valid)
		begin
			case (opcode_of(prefix))
			EXI8:
				imm_ext = VALUE_W'($signed({prefix[PFX_LSB +: EXI8_W-1],
					prefix[PFX_LO_BIT], imm_base[IMM_KEEP_W-1:0]}));
			EXI24:
				imm_ext = VALUE_W'($signed({prefix[PFX_LSB +: EXI24_W-1],
					prefix[PFX_LO_BIT], imm_base[IMM_KEEP_W-1:0]}));
			default:
				imm_ext = imm_base;
			endcase
		end
	end

	// ============================================================
	// Branch target, halfword scaled
	// ============================================================
	always_comb
	begin
		case (opc)
		JEQ, JNE:
			tgt = VALUE_W'($signed({insn[JXX_TGT_LSB +: JXX_TGT_W], 1'b0}));
		default:
			tgt = VALUE_W'($signed({insn[JMP_TGT_LSB +: JMP_TGT_W], 1'b0}));
		endcase
	end

	// Widen to the record width
	assign imm    = VALUE_MAX'($signed(imm_ext));
	assign jmptgt = VALUE_MAX'($signed(tgt));

endmodule

`default_nettype wire

// ==== thor_ctrl_class.sv ====
// Control classification of an instruction: write-back, memory access and flow change
`timescale 1ns/1ps
`default_nettype none

module thor_ctrl_class (
	input  wire  thor_isa_pkg::insn_t      insn,
	output logic                           rfwr,
	output logic                           ld,
	output logic                           ldz,
	output logic                           st,
	output logic                           jmp,
	output logic                           jxx,
	output thor_decode_pkg::mem_size_e     memsz
);

	import thor_isa_pkg::*;
	import thor_decode_pkg::*;

	opcode_e opc;

	assign opc = opcode_of(insn);

	// Register file update
	always_comb
	begin
		case (opc)
		R2, R3:
			rfwr = 1'b1;
		ADDI, ANDI, ORI, XORI:
			rfwr = 1'b1;
		LDB, LDBU, LDW, LDWU, LDO:
			rfwr = 1'b1;
		default:
			rfwr = 1'b0;
		endcase
	end

	// ============================================================
	// Memory access
	// ============================================================
	always_comb
	begin
		case (opc)
		LDB, LDBU, LDW, LDWU, LDO:
			ld = 1'b1;
		default:
			ld = 1'b0;
		endcase

		// Unsigned loads zero fill
		case (opc)
		LDBU, LDWU:
			ldz = 1'b1;
		default:
			ldz = 1'b0;
		endcase

		case (opc)
		STB, STW, STO:
			st = 1'b1;
		default:
			st = 1'b0;
		endcase

		case (opc)
		LDB, LDBU, STB:
			memsz = byt;
		LDW, LDWU, STW:
			memsz = wyde;
		default:
			memsz = octa;
		endcase
	end

	// Flow change
	always_comb
	begin
		case (opc)
		JMP:
			jmp = 1'b1;
		default:
			jmp = 1'b0;
		endcase

		case (opc)
		JEQ, JNE:
			jxx = 1'b1;
		default:
			jxx = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== thor_decode_pkg.sv ====
// Request and decode record types exchanged between the decode unit and its requester
`default_nettype none

package thor_decode_pkg;

	// Widest constant the decode record can carry
	localparam int VALUE_MAX = 128;

	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd2
	} mem_size_e;

	// One decode request: instruction plus optional EXI prefix
	typedef struct packed {
		thor_isa_pkg::insn_t                   insn;
		logic [thor_isa_pkg::PREFIX_W-1:0]     prefix;
		logic                                  prefix_valid;
	} decode_req_t;

	// ============================================================
	// Registered decode record
	// ============================================================
	typedef struct packed {
		logic [thor_isa_pkg::REG_W-1:0] ra;
		logic [thor_isa_pkg::REG_W-1:0] rb;
		logic [thor_isa_pkg::REG_W-1:0] rc;
		logic [thor_isa_pkg::REG_W-1:0] rt;
		logic                           rfwr;
		logic                           ld;
		logic                           ldz;
		logic                           st;
		mem_size_e                      memsz;
		logic                           jmp;
		logic                           jxx;
		// Upper bits above the active width are a sign copy
		logic [VALUE_MAX-1:0]           imm;
		logic [VALUE_MAX-1:0]           jmptgt;
	} decode_out_t;

endpackage

`default_nettype wire

// ==== thor_decode_unit.sv ====
// Decoder top level; four-phase req/ack handshake around the registered decode record
`timescale 1ns/1ps
`default_nettype none

module thor_decode_unit #(
	parameter int VALUE_W = 64
) (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  req,
	output logic                                 ack,
	input  wire  thor_decode_pkg::decode_req_t   request,
	output thor_decode_pkg::decode_out_t         decode
);

	import thor_isa_pkg::*;
	import thor_decode_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_done
	} hs_state_e;

	hs_state_e              state;
	decode_req_t            req_q;
	decode_out_t            dec_next;
	logic [REG_W-1:0]       ra;
	logic [REG_W-1:0]       rb;
	logic [REG_W-1:0]       rc;
	logic [REG_W-1:0]       rt;
	logic [VALUE_MAX-1:0]   imm;
	logic [VALUE_MAX-1:0]   jmptgt;
	logic                   rfwr;
	logic                   ld;
	logic                   ldz;
	logic                   st;
	logic                   jmp;
	logic                   jxx;
	mem_size_e              memsz;

	// ============================================================
	// Handshake controller
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			ack   <= 1'b0;
		end
		else
		begin
			case (state)
			st_idle:
				if (req)
					state <= st_busy;
			st_busy:
				state <= st_done;
			st_done:
				// Record is loaded here, ack follows a cycle later and holds while req is high
				if (!ack)
					ack <= 1'b1;
				else if (!req)
				begin
					ack   <= 1'b0;
					state <= st_idle;
				end
			default:
				state <= st_idle;
			endcase
		end
	end

	// Input capture and output record
	always_ff @(posedge clk)
	begin
		if (state == st_idle && req)
			req_q <= request;
		if (state == st_busy)
			decode <= dec_next;
	end

	// ============================================================
	// Decode datapath
	// ============================================================
	thor_reg_spec u_reg_spec (
		.insn (req_q.insn),
		.ra   (ra),
		.rb   (rb),
		.rc   (rc),
		.rt   (rt)
	);

	thor_const_gen #(
		.VALUE_W (VALUE_W)
	) u_const_gen (
		.insn         (req_q.insn),
		.prefix       (req_q.prefix),
		.prefix_valid (req_q.prefix_valid),
		.imm          (imm),
		.jmptgt       (jmptgt)
	);

	thor_ctrl_class u_ctrl_class (
		.insn  (req_q.insn),
		.rfwr  (rfwr),
		.ld    (ld),
		.ldz   (ldz),
		.st    (st),
		.jmp   (jmp),
		.jxx   (jxx),
		.memsz (memsz)
	);

	always_comb
	begin
		dec_next.ra     = ra;
		dec_next.rb     = rb;
		dec_next.rc     = rc;
		dec_next.rt     = rt;
		dec_next.rfwr   = rfwr;
		dec_next.ld     = ld;
		dec_next.ldz    = ldz;
		dec_next.st     = st;
		dec_next.memsz  = memsz;
		dec_next.jmp    = jmp;
		dec_next.jxx    = jxx;
		dec_next.imm    = imm;
		dec_next.jmptgt = jmptgt;
	end

endmodule

`default_nettype wire

// ==== thor_isa_pkg.sv ====
// Instruction set layout for the decoder: word widths, opcode values and field positions
`default_nettype none

package thor_isa_pkg;

	// ============================================================
	// Word and field widths
	// ============================================================
	localparam int INSN_W   = 48;
	localparam int PREFIX_W = 48;
	localparam int REG_W    = 5;
	localparam int OPC_W    = 8;

	typedef logic [INSN_W-1:0] insn_t;

	typedef enum logic [OPC_W-1:0] {
		R2    = 8'h02,
		R3    = 8'h03,
		ADDI  = 8'h04,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		JMP   = 8'h20,
		JEQ   = 8'h26,
		JNE   = 8'h27,
		EXI8  = 8'h50,
		EXI24 = 8'h52,
		LDB   = 8'h80,
		LDBU  = 8'h81,
		LDW   = 8'h82,
		LDWU  = 8'h83,
		LDO   = 8'h86,
		STB   = 8'h90,
		STW   = 8'h91,
		STO   = 8'h93,
		NOP   = 8'hF1
	} opcode_e;

	// ============================================================
	// Field positions
	// ============================================================
	localparam int OPC_LSB = 0;
	// Stores reuse the Rt slot as the source register Rs
	localparam int RT_LSB  = 9;
	localparam int RA_LSB  = 14;
	localparam int RB_LSB  = 19;
	localparam int RC_LSB  = 24;

	// Immediate of ri forms, also the load/store displacement
	localparam int IMM_LSB = 19;
	localparam int IMM_W   = 13;

	// Conditional branch target
	localparam int JXX_TGT_LSB = 28;
	localparam int JXX_TGT_W   = 20;

	// Unconditional jump target
	localparam int JMP_TGT_LSB = 16;
	localparam int JMP_TGT_W   = 32;

	// Prefix payload starts at bit 9, with bit 0 as its lowest bit
	localparam int PFX_LSB    = 9;
	localparam int PFX_LO_BIT = 0;
	localparam int EXI8_W     = 8;
	localparam int EXI24_W    = 24;

	// Low part of the immediate that survives a prefix
	localparam int IMM_KEEP_W = 24;

	// Link register, used as Ra by JMP
	localparam logic [REG_W-1:0] LINK_REG = 5'd26;

	function automatic opcode_e opcode_of(input insn_t word);
		opcode_of = opcode_e'(word[OPC_LSB +: OPC_W]);
	endfunction

endpackage

`default_nettype wire

// ==== thor_reg_spec.sv ====
// Register specifier selection; combinational, one instance in the decode unit
`timescale 1ns/1ps
`default_nettype none

module thor_reg_spec (
	input  wire  thor_isa_pkg::insn_t             insn,
	output logic [thor_isa_pkg::REG_W-1:0]        ra,
	output logic [thor_isa_pkg::REG_W-1:0]        rb,
	output logic [thor_isa_pkg::REG_W-1:0]        rc,
	output logic [thor_isa_pkg::REG_W-1:0]        rt
);

	import thor_isa_pkg::*;

	opcode_e opc;

	assign opc = opcode_of(insn);

	always_comb
	begin
		// JMP saves the return address through the link register
		case (opc)
		JMP:
			ra = LINK_REG;
		default:
			ra = insn[RA_LSB +: REG_W];
		endcase

		rb = insn[RB_LSB +: REG_W];

		// Store data comes from the Rs slot
		case (opc)
		STB, STW, STO:
			rc = insn[RT_LSB +: REG_W];
		default:
			rc = insn[RC_LSB +: REG_W];
		endcase

		// Target register, zero when nothing is written back
		case (opc)
		STB, STW, STO:
			rt = '0;
		JMP, JEQ, JNE:
			rt = '0;
		EXI8, EXI24:
			rt = '0;
		default:
			rt = insn[RT_LSB +: REG_W];
		endcase
	end

endmodule

`default_nettype wire
